// File: filelist.f
common/isa_pkg.sv
common/irq_pkg.sv
common/mc_if.sv
common/irq_if.sv
hw/irq_gate.sv
reglist/reglist_seq.sv
hw/ins_extract_mux.sv
hw/extract_stage.sv
dv/extract_asserts.sv
dv/tb_extract_stage.sv

// File: run_sim.sh
#!/bin/sh
# Builds the extract stage testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_extract_stage \
	-f filelist.f -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -qx "All checks passed" sim.log; then
	exit 0
else
	echo "pass line not found in sim.log"
	exit 1
fi

// File: dv/tb_extract_stage.sv
// Table-driven testbench for the extract stage, run as top module with the DUT as dut0
`timescale 1ns/1ns

module tb_extract_stage import isa_pkg::*, irq_pkg::*; ();

	typedef struct packed {
		logic         en;
		logic         nop;
		instruction_t insi;
		irq_level_t   irq_i;
		irq_vect_t    vect_i;
		instruction_t exp_ins;
		logic         exp_hold;
	} row_t;

	logic         clk;
	logic         rst;
	logic         en;
	logic         nop;
	instruction_t insi;
	irq_level_t   irq_i;
	irq_vect_t    vect_i;
	instruction_t ins;
	logic         hold;

	// Each row holds the stimulus and the expected response of one clock
	row_t rows[$];

	extract_stage dut0 (
		.clk    (clk),
		.rst    (rst),
		.en     (en),
		.nop    (nop),
		.insi   (insi),
		.irq_i  (irq_i),
		.vect_i (vect_i),
		.ins    (ins),
		.hold   (hold)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ==============================
	// Instruction builders
	// ==============================

	function automatic instruction_t mk_ins(opcode_t op, logic [PAYLOAD_W-1:0] payload);
		instruction_t i;
		i.opcode  = op;
		i.payload = payload;
		return i;
	endfunction

	// The injected interrupt payload holds 16 zeros, the function, a zero, vector and level
	function automatic instruction_t sys_irq(irq_vect_t v, irq_level_t l);
		return mk_ins(OP_SYS, {16'b0, FN_IRQ, 1'b0, v, l});
	endfunction

	function automatic logic [MASK_W-1:0] rand_mask();
		logic [MASK_W-1:0] m;
		m = MASK_W'($urandom);
		if (m == '0)
			m = 16'h0001;
		return m;
	endfunction

	task automatic add_row(input logic e, input logic n, input instruction_t i,
		input irq_level_t l, input irq_vect_t v, input instruction_t x, input logic h);
		rows.push_back('{e, n, i, l, v, x, h});
	endtask

	// List instruction, then one micro-op per set bit in ascending order, then the held word
	// An interrupt may be raised with micro-op irq_k, and en may drop after micro-op stall_k
	task automatic add_list(input opcode_t op, input logic [MASK_W-1:0] mask,
		input instruction_t next, input int irq_k, input irq_level_t lvl, input irq_vect_t v,
		input int stall_k, input int stall_n);
		opcode_t           uop;
		logic [MASK_W-1:0] rest;
		instruction_t      uins;
		int                k;
		uop  = (op == OP_PUSHM) ? OP_PUSH : OP_POP;
		rest = mask;
		k    = 0;
		add_row(1'b1, 1'b0, mk_ins(op, {17'b0, mask}), '0, '0, mk_ins(op, {17'b0, mask}),
			mask != '0);
		for (int b = 0; b < MASK_W; b++) begin
			if (mask[b]) begin
				rest[b] = 1'b0;
				uins    = mk_ins(uop, PAYLOAD_W'(b));
				if (k == irq_k) begin
					add_row(1'b1, 1'b0, next, lvl, v, uins, rest != '0);
					// The interrupt goes out ahead of the next register
					add_row(1'b1, 1'b0, next, '0, '0, sys_irq(v, lvl), rest != '0);
				end else begin
					add_row(1'b1, 1'b0, next, '0, '0, uins, rest != '0);
				end
				if (k == stall_k)
					repeat (stall_n) add_row(1'b0, 1'b0, next, '0, '0, uins, rest != '0);
				k++;
			end
		end
		add_row(1'b1, 1'b0, next, '0, '0, next, 1'b0);
	endtask

	// ==============================
	// Checks
	// ==============================

	task automatic stop_on_error();
		$display("Checks failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_ins(input instruction_t exp, input instruction_t act);
		if (act !== exp) begin
			$display("mismatch at %0t ns: ins expected %s (%h), actual %s (%h)",
				$time, exp.opcode.name(), exp, act.opcode.name(), act);
			stop_on_error();
		end
	endtask

	task automatic check_hold(input logic exp, input logic act);
		if (act !== exp) begin
			$display("mismatch at %0t ns: hold expected %b, actual %b", $time, exp, act);
			stop_on_error();
		end
	endtask

	task automatic wait_hold_low(input int limit);
		int n;
		n = 0;
		while (hold !== 1'b0 && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (hold !== 1'b0) begin
			$display("timeout: hold still high after %0d cycles", limit);
			stop_on_error();
		end
	endtask

	// ==============================
	// Table and run
	// ==============================

	initial begin
		instruction_t i_add;
		instruction_t i_load;
		instruction_t i_store;
		irq_vect_t    va;
		irq_vect_t    vb;
		void'($urandom(32'hacce2352));
		rst    = 1'b1;
		en     = 1'b0;
		nop    = 1'b0;
		insi   = NOP_INS;
		irq_i  = '0;
		vect_i = '0;
		i_add   = mk_ins(OP_ADD, '0);
		i_load  = mk_ins(OP_LOAD, '0);
		i_store = mk_ins(OP_STORE, '0);
		va = irq_vect_t'($urandom);
		vb = irq_vect_t'($urandom);
		// Pass-through, then en low keeps ins
		add_row(1'b1, 1'b0, i_add, '0, '0, i_add, 1'b0);
		add_row(1'b1, 1'b0, i_load, '0, '0, i_load, 1'b0);
		add_row(1'b0, 1'b0, i_store, '0, '0, i_load, 1'b0);
		add_row(1'b0, 1'b0, i_store, '0, '0, i_load, 1'b0);
		add_row(1'b1, 1'b0, i_store, '0, '0, i_store, 1'b0);
		// Forced NOP overrides insi
		add_row(1'b1, 1'b1, i_add, '0, '0, NOP_INS, 1'b0);
		add_row(1'b1, 1'b0, i_add, '0, '0, i_add, 1'b0);
		// Single request is latched, injected once, then fetch resumes
		add_row(1'b1, 1'b0, i_load, 3'd3, va, i_load, 1'b0);
		add_row(1'b1, 1'b0, i_store, '0, '0, sys_irq(va, 3'd3), 1'b0);
		add_row(1'b1, 1'b0, i_store, '0, '0, i_store, 1'b0);
		// A higher level replaces the pending one while en is low, a lower one is dropped
		add_row(1'b1, 1'b0, i_add, 3'd2, va, i_add, 1'b0);
		add_row(1'b0, 1'b0, i_add, 3'd5, vb, i_add, 1'b0);
		add_row(1'b0, 1'b0, i_add, 3'd1, ~vb, i_add, 1'b0);
		add_row(1'b1, 1'b0, i_load, '0, '0, sys_irq(vb, 3'd5), 1'b0);
		add_row(1'b1, 1'b0, i_load, '0, '0, i_load, 1'b0);
		// Plain expansions, and a zero mask that passes alone
		add_list(OP_PUSHM, rand_mask(), i_load, -1, '0, '0, -1, 0);
		add_list(OP_POPM, rand_mask(), i_store, -1, '0, '0, -1, 0);
		add_list(OP_PUSHM, '0, i_add, -1, '0, '0, -1, 0);
		// Interrupt after the second micro-op, then a three cycle stall
		add_list(OP_PUSHM, rand_mask() | 16'h8101, i_load, 1, 3'd6, vb, -1, 0);
		add_list(OP_POPM, rand_mask() | 16'h8101, i_store, -1, '0, '0, 1, 3);
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		check_ins(NOP_INS, ins);
		check_hold(1'b0, hold);
		foreach (rows[i]) begin
			en     = rows[i].en;
			nop    = rows[i].nop;
			insi   = rows[i].insi;
			irq_i  = rows[i].irq_i;
			vect_i = rows[i].vect_i;
			@(posedge clk);
			@(negedge clk);
			check_ins(rows[i].exp_ins, ins);
			check_hold(rows[i].exp_hold, hold);
		end
		wait_hold_low(40);
		$display("All checks passed");
		$finish;
	end

endmodule

// File: dv/extract_asserts.sv
// Concurrent checks on the take strobes and sequencer state, attached to the mux and sequencer by bind
`timescale 1ns/1ns

module extract_asserts (
	input logic clk,
	input logic rst,
	input logic irq_take,
	input logic mc_take,
	input logic ins_take,
	input logic mipv,
	input logic seq_idle
);

	// The mux grants at most one source per cycle
	a_single_take: assert property (@(posedge clk) disable iff (rst) !(irq_take && mc_take))
		else $error("interrupt and micro-op were taken in the same cycle");

	// A valid micro-op only exists while the sequencer is expanding
	a_idle_no_mipv: assert property (@(posedge clk) disable iff (rst) seq_idle |-> !mipv)
		else $error("micro-op valid while the sequencer is idle");

	// Fetch is held for the whole expansion
	a_hold_blocks_fetch: assert property (@(posedge clk) disable iff (rst) mipv |-> !ins_take)
		else $error("fetched instruction taken while a micro-op was pending");

endmodule

// The mux sees every strobe but not the sequencer state
bind ins_extract_mux extract_asserts mux_chk (
	.clk      (clk),
	.rst      (rst),
	.irq_take (irq.irq_take),
	.mc_take  (mc.mc_take),
	.ins_take (mc.ins_take),
	.mipv     (mc.mipv),
	.seq_idle (1'b0)
);

// The sequencer has its own state but no view of the interrupt strobe
bind reglist_seq extract_asserts seq_chk (
	.clk      (clk),
	.rst      (rst),
	.irq_take (1'b0),
	.mc_take  (mc.mc_take),
	.ins_take (mc.ins_take),
	.mipv     (mc.mipv),
	.seq_idle (state_q == SEQ_IDLE)
);

// File: hw/extract_stage.sv
// Top level of the extract stage, joining interrupt gate, list sequencer and mux to plain ports
`timescale 1ns/1ns

module extract_stage import isa_pkg::*, irq_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  logic         en,
	input  logic         nop,
	input  instruction_t insi,
	input  irq_level_t   irq_i,
	input  irq_vect_t    vect_i,
	output instruction_t ins,
	output logic         hold
);

	// Sequencer to mux, and gate to mux
	mc_if  mc0 ();
	irq_if irq0 ();

	// Pending interrupt request
	irq_gate u_irq_gate (
		.clk    (clk),
		.rst    (rst),
		.irq_i  (irq_i),
		.vect_i (vect_i),
		.irq    (irq0.gate)
	);

	// Register-list expansion
	reglist_seq u_reglist_seq (
		.clk  (clk),
		.rst  (rst),
		.insi (insi),
		.mc   (mc0.seq)
	);

	// Priority choice and output register
	ins_extract_mux u_ins_extract_mux (
		.clk  (clk),
		.rst  (rst),
		.en   (en),
		.nop  (nop),
		.insi (insi),
		.mc   (mc0.mux),
		.irq  (irq0.mux),
		.ins  (ins)
	);

	// Fetch must keep insi steady while micro-ops are pending
	assign hold = mc0.mipv;

endmodule

// File: hw/ins_extract_mux.sv
// Picks interrupt, micro-op, NOP or fetched instruction by fixed priority and registers the choice
`timescale 1ns/1ns

module ins_extract_mux import isa_pkg::*, irq_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  logic         en,
	input  logic         nop,
	input  instruction_t insi,
	mc_if.mux            mc,
	irq_if.mux           irq,
	output instruction_t ins
);

	instruction_t irq_ins;
	instruction_t ins_nxt;

	// ==============================
	// Interrupt instruction
	// ==============================

	// OP_SYS payload from the top is zero padding, function, a zero bit, vector and level
	always_comb begin
		irq_ins.opcode  = OP_SYS;
		irq_ins.payload = {{(PAYLOAD_W - FN_W - 1 - VECT_W - LVL_W){1'b0}},
			FN_IRQ, 1'b0, irq.vect, irq.lvl};
	end

	// ==============================
	// Priority and take strobes
	// ==============================

	// Priority is decided here only and the gate and sequencer just obey the strobes
	always_comb begin
		irq.irq_take = en & irq.hirq;
		mc.mc_take   = en & ~irq.hirq & mc.mipv;
		mc.ins_take  = en & ~irq.hirq & ~mc.mipv & ~nop;
	end

	// Interrupt first, then micro-op, then a forced NOP, else the fetched word
	always_comb begin
		if (irq.hirq)
			ins_nxt = irq_ins;
		else if (mc.mipv)
			ins_nxt = mc.mc_ins;
		else if (nop)
			ins_nxt = NOP_INS;
		else
			ins_nxt = insi;
	end

	// Latency is one cycle and the output holds while en is low
	always_ff @(posedge clk) begin
		if (rst)
			ins <= NOP_INS;
		else if (en)
			ins <= ins_nxt;
	end

endmodule

// File: reglist/reglist_seq.sv
// Expands PUSHM and POPM register lists into single PUSH or POP micro-ops in ascending order
`timescale 1ns/1ns

module reglist_seq import isa_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  instruction_t insi,
	mc_if.seq            mc
);

	typedef enum logic [0:0] {
		SEQ_IDLE   = 1'b0,
		SEQ_EXPAND = 1'b1
	} seq_state_t;

	seq_state_t        state_q;
	logic [MASK_W-1:0] mask_q;
	logic [MASK_W-1:0] mask_nxt;
	logic [MASK_W-1:0] mask_in;
	logic              pop_q;
	logic              is_list;
	logic              start;
	logic [REG_W-1:0]  low_reg;

	// ==============================
	// Decode of the taken instruction
	// ==============================

	assign mask_in = insi.payload[MASK_W-1:0];
	assign is_list = (insi.opcode == OP_PUSHM) || (insi.opcode == OP_POPM);

	// A zero mask passes downstream alone and starts nothing
	assign start = mc.ins_take && is_list && (mask_in != '0);

	// ==============================
	// Lowest set register
	// ==============================

	// Scan from the top so the lowest set bit wins
	always_comb begin
		low_reg = '0;
		for (int i = MASK_W - 1; i >= 0; i--) begin
			if (mask_q[i])
				low_reg = REG_W'(i);
		end
	end

	// Clearing the lowest set bit leaves the registers still to go
	assign mask_nxt = mask_q & (mask_q - 1'b1);

	// ==============================
	// State machine
	// ==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= SEQ_IDLE;
		end else begin
			case (state_q)
				SEQ_IDLE: begin
					if (start)
						state_q <= SEQ_EXPAND;
				end
				SEQ_EXPAND: begin
					// Leave at the edge that takes the last register
					if (mc.mc_take && (mask_nxt == '0))
						state_q <= SEQ_IDLE;
				end
				default: state_q <= SEQ_IDLE;
			endcase
		end
	end

	// Mask and direction load on the list instruction and shrink on each take
	always_ff @(posedge clk) begin
		if (start) begin
			mask_q <= mask_in;
			pop_q  <= (insi.opcode == OP_POPM);
		end else if (mc.mc_take) begin
			mask_q <= mask_nxt;
		end
	end

	// The micro-op names the lowest remaining register in its low payload bits
	always_comb begin
		mc.mc_ins.opcode  = pop_q ? OP_POP : OP_PUSH;
		mc.mc_ins.payload = {{(PAYLOAD_W - REG_W){1'b0}}, low_reg};
	end

	// The micro-op stays valid for the whole expansion and this also holds fetch
	assign mc.mipv = (state_q == SEQ_EXPAND);

endmodule

// File: hw/irq_gate.sv
// Latches one hardware interrupt request and holds it until the extract mux injects it
`timescale 1ns/1ns

module irq_gate import irq_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  irq_level_t irq_i,
	input  irq_vect_t  vect_i,
	irq_if.gate        irq
);

	logic       pend;
	irq_level_t lvl_q;
	irq_vect_t  vect_q;
	logic       accept;

	// A request is taken if nothing is pending or if it outranks the pending one
	// A lower or equal arrival is dropped, also in the cycle of an injection
	assign accept = (irq_i != '0) && (!pend || (irq_i > lvl_q));

	// The pending flag is the only control state here
	always_ff @(posedge clk) begin
		if (rst)
			pend <= 1'b0;
		else if (accept)
			pend <= 1'b1;
		else if (irq.irq_take)
			pend <= 1'b0;
	end

	// Level and vector follow the accepted request
	always_ff @(posedge clk) begin
		if (accept) begin
			lvl_q  <= irq_i;
			vect_q <= vect_i;
		end
	end

	// Outputs come straight from the registers, so hirq rises the cycle after latching
	assign irq.hirq = pend;
	assign irq.lvl  = lvl_q;
	assign irq.vect = vect_q;

endmodule

// File: common/irq_if.sv
// Connects the interrupt gate to the extract mux, carrying the pending request and its take strobe
`timescale 1ns/1ns

interface irq_if import irq_pkg::*; ();

	// This level is high while a request is pending in the gate
	logic hirq;

	// Level and vector of the pending request
	irq_level_t lvl;
	irq_vect_t  vect;

	// One-cycle strobe from the mux when the interrupt is injected
	logic irq_take;

	modport gate (
		output hirq,
		output lvl,
		output vect,
		input  irq_take
	);

	modport mux (
		input  hirq,
		input  lvl,
		input  vect,
		output irq_take
	);

endinterface

// File: common/mc_if.sv
// Connects the register-list sequencer to the extract mux, carrying micro-ops and take strobes
`timescale 1ns/1ns

interface mc_if import isa_pkg::*; ();

	// Micro-op presented by the sequencer
	instruction_t mc_ins;

	// This level is high while mc_ins is valid and waiting to be taken
	logic mipv;

	// One-cycle strobe from the mux when the micro-op is registered downstream
	logic mc_take;

	// One-cycle strobe from the mux when the fetched instruction is registered
	logic ins_take;

	modport seq (
		output mc_ins,
		output mipv,
		input  mc_take,
		input  ins_take
	);

	modport mux (
		input  mc_ins,
		input  mipv,
		output mc_take,
		output ins_take
	);

endinterface

// File: common/irq_pkg.sv
// Hardware interrupt level and vector types used by the interrupt gate, the mux and the testbench
package irq_pkg;

	// ==============================
	// Widths
	// ==============================

	localparam int LVL_W  = 3;
	localparam int VECT_W = 9;

	// Level zero means no request is present
	// A larger level is more urgent and may replace a pending smaller one
	typedef logic [LVL_W-1:0] irq_level_t;

	// Vector number carried into the OP_SYS payload
	typedef logic [VECT_W-1:0] irq_vect_t;

endpackage

// File: common/isa_pkg.sv
// Instruction format, opcodes and field widths shared by the extract stage and its testbench
package isa_pkg;

	// ==============================
	// Field widths
	// ==============================

	localparam int OPC_W     = 7;
	localparam int PAYLOAD_W = 33;
	localparam int MASK_W    = 16;
	localparam int REG_W     = 5;
	// System function field inside an OP_SYS payload
	localparam int FN_W      = 4;

	// ==============================
	// Encodings
	// ==============================

	// OP_NOP must stay zero so that an all-zero word is a NOP
	typedef enum logic [OPC_W-1:0] {
		OP_NOP   = 7'd0,
		OP_ADD   = 7'd1,
		OP_LOAD  = 7'd2,
		OP_STORE = 7'd3,
		OP_SYS   = 7'd4,
		OP_PUSHM = 7'd5,
		OP_POPM  = 7'd6,
		OP_PUSH  = 7'd7,
		OP_POP   = 7'd8
	} opcode_t;

	typedef enum logic [FN_W-1:0] {
		FN_NONE = 4'd0,
		FN_IRQ  = 4'd1
	} sys_fn_t;

	// The payload sits above the opcode and the word is 40 bits in all
	// The payload layout depends on the opcode and is decoded by the consumer
	typedef struct packed {
		logic [PAYLOAD_W-1:0] payload;
		opcode_t              opcode;
	} instruction_t;

	localparam instruction_t NOP_INS = '{payload: '0, opcode: OP_NOP};

endpackage
